/* design/pc_soc_pkg.sv */
// Shared bus types, PIC vector base and I/O port map of the SoC, imported by every module
package pc_soc_pkg;

  // Bus data word
  typedef logic [15:0] word_t;

  // Word address, bits 19 to 1 of the physical address
  typedef logic [19:1] addr_t;

  // Byte select, bit 0 is the low byte
  typedef logic [1:0] sel_t;

  // Interrupt request lines and index
  typedef logic [7:0] irq_t;
  typedef logic [2:0] iid_t;

  // Upper bits of the acknowledge vector, giving 08h + iid
  localparam logic [12:0] PIC_VECTOR_BASE = 13'h0001;

  // LED latch answers on ports F1xxh
  localparam logic [7:0] LED_PORT_HI = 8'hF1;

  // Word addresses of the read ports (0102h and 0064h)
  localparam logic [14:0] SW_PORT       = 15'h0081;
  localparam logic [14:0] KBD_STAT_PORT = 15'h0032;

  // Keyboard status is fixed, inhibit bit set
  localparam word_t KBD_STAT_VALUE = 16'h0010;

  // Floating bus value for ports nobody answers
  localparam word_t UNMAPPED_IO_VALUE = 16'hFFFF;

endpackage

/* design/bus_decode.sv */
// Splits the master bus into memory and I/O arenas and returns ack and read data to the master
module bus_decode
  import pc_soc_pkg::*;
(
  input  logic  cyc_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  logic  tga_i,
  input  addr_t adr_i,
  input  logic  inta_i,
  input  iid_t  iid_i,
  input  logic  ram_ack_i,
  input  word_t ram_dat_i,
  input  logic  io_ack_i,
  input  word_t io_dat_i,
  output logic  ram_stb_o,
  output logic  io_stb_o,
  output logic  ack_o,
  output word_t dat_o
);

  logic  bus_req;
  logic  io_space;
  word_t rd_dat;

  // A transfer is live only with both strobe and cycle
  assign bus_req = stb_i & cyc_i;

  // I/O ports are 16 bits wide, anything above is outside the port space
  assign io_space = (adr_i[19:16] == 4'h0);

  // Every memory cycle goes to RAM, addresses wrap inside it
  assign ram_stb_o = bus_req & ~tga_i;
  assign io_stb_o  = bus_req & tga_i & io_space;

  // Out-of-range port cycles are answered here at once
  always_comb begin
    if (!tga_i) begin
      ack_o = ram_ack_i;
    end else if (io_space) begin
      ack_o = io_ack_i;
    end else begin
      ack_o = bus_req;
    end
  end

  always_comb begin
    if (!tga_i) begin
      rd_dat = ram_dat_i;
    end else if (io_space) begin
      rd_dat = io_dat_i;
    end else begin
      rd_dat = UNMAPPED_IO_VALUE;
    end
  end

  // Vector fetch wins over any bus data
  // Write cycles return zero instead of stale slave data
  always_comb begin
    if (inta_i) begin
      dat_o = {PIC_VECTOR_BASE, iid_i};
    end else if (we_i) begin
      dat_o = '0;
    end else begin
      dat_o = rd_dat;
    end
  end

endmodule

/* design/conv_ram.sv */
// Word-wide conventional RAM slave with byte writes and a one-cycle registered acknowledge
module conv_ram
  import pc_soc_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  logic  clk,
  input  logic  rst_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  sel_t  sel_i,
  input  word_t dat_i,
  output word_t dat_o,
  output logic  ack_o
);

  localparam int DEPTH = 2 ** RAM_AW;

  word_t             mem [DEPTH];
  logic [RAM_AW-1:0] idx;
  logic              ack_q;
  logic              first;
  word_t             dat_q;

  // Upper address bits are ignored, so the array aliases
  assign idx = adr_i[RAM_AW:1];

  // First strobe cycle, the one that launches the access
  assign first = stb_i & ~ack_q;

  // Ack follows the strobe one cycle late and drops one cycle after it
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i;
    end
  end

  // Write lands on the edge that raises ack
  always_ff @(posedge clk) begin
    if (first && we_i) begin
      if (sel_i[0]) begin
        mem[idx][7:0] <= dat_i[7:0];
      end
      if (sel_i[1]) begin
        mem[idx][15:8] <= dat_i[15:8];
      end
    end
  end

  // Read word captured once, held while ack is up
  always_ff @(posedge clk) begin
    if (first) begin
      dat_q <= mem[idx];
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;

endmodule

/* design/io_regs.sv */
// Basic I/O ports on the port bus: LED latch, switch input and keyboard status
module io_regs
  import pc_soc_pkg::*;
(
  input  logic  clk,
  input  logic  rst_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  word_t dat_i,
  input  word_t sw_i,
  output word_t dat_o,
  output logic  ack_o,
  output word_t led_o
);

  word_t led_q;

  // Whole F1xxh range hits the latch, low port byte is ignored
  always_ff @(posedge clk) begin
    if (rst_i) begin
      led_q <= '0;
    end else if (stb_i && we_i && adr_i[15:8] == LED_PORT_HI) begin
      led_q <= dat_i;
    end
  end

  // Read ports, decoded on the word address
  always_comb begin
    case (adr_i[15:1])
      SW_PORT:       dat_o = sw_i;
      KBD_STAT_PORT: dat_o = KBD_STAT_VALUE;
      default:       dat_o = UNMAPPED_IO_VALUE;
    endcase
  end

  // No wait states on the port bus
  assign ack_o = stb_i;
  assign led_o = led_q;

endmodule

/* design/pit_timer.sv */
// Phase-accumulator interval timer, one tick per wrap of the accumulator's top bit
module pit_timer #(
  parameter int TIMER_RES   = 12,
  parameter int TIMER_PHASE = 37
) (
  input  logic clk,
  input  logic rst_i,
  output logic tick_o
);

  localparam int MSB = TIMER_RES - 1;

  logic [MSB:0] acc;
  logic [MSB:0] acc_nx;
  logic         tick_q;

  assign acc_nx = acc + TIMER_RES'(TIMER_PHASE);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      acc <= '0;
    end else begin
      acc <= acc_nx;
    end
  end

  // High in the cycle the top bit first reads as one
  always_ff @(posedge clk) begin
    if (rst_i) begin
      tick_q <= 1'b0;
    end else begin
      tick_q <= ~acc[MSB] & acc_nx[MSB];
    end
  end

  assign tick_o = tick_q;

endmodule

/* design/simple_pic.sv */
// Eight-line edge-triggered interrupt controller, lowest line has top priority
module simple_pic
  import pc_soc_pkg::*;
(
  input  logic clk,
  input  logic rst_i,
  input  irq_t irq_i,
  input  logic inta_i,
  output logic intr_o,
  output iid_t iid_o
);

  irq_t irq_q;
  irq_t rise;
  irq_t pending;
  irq_t clr;
  iid_t iid;

  // Edge detect against last cycle's levels
  assign rise = irq_i & ~irq_q;

  // Lowest pending index, scanned from the top so line 0 wins
  always_comb begin
    iid = '0;
    for (int i = 7; i >= 0; i--) begin
      if (pending[i]) begin
        iid = iid_t'(i);
      end
    end
  end

  // Acknowledge retires the line being served
  assign clr = inta_i ? irq_t'(1) << iid : '0;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_q   <= '0;
      pending <= '0;
    end else begin
      irq_q   <= irq_i;
      // A fresh edge on the served line re-arms it
      pending <= (pending & ~clr) | rise;
    end
  end

  assign intr_o = |pending;
  assign iid_o  = iid;

endmodule

/* design/pc_soc_top.sv */
// SoC top level wiring the master bus to the decoder, RAM, I/O ports, timer and PIC
module pc_soc_top
  import pc_soc_pkg::*;
#(
  parameter int RAM_AW      = 10,
  parameter int TIMER_RES   = 12,
  parameter int TIMER_PHASE = 37
) (
  input  logic       clk,
  input  logic       rst_i,
  // Master bus, driven by the CPU side
  input  logic       cyc_i,
  input  logic       stb_i,
  input  logic       we_i,
  input  logic       tga_i,
  input  addr_t      adr_i,
  input  sel_t       sel_i,
  input  word_t      dat_i,
  input  logic       inta_i,
  output word_t      dat_o,
  output logic       ack_o,
  output logic       intr_o,
  // Board side
  input  logic [7:1] irq_i,
  input  word_t      sw_i,
  output word_t      led_o
);

  logic  ram_stb;
  logic  ram_ack;
  word_t ram_dat;
  logic  io_stb;
  logic  io_ack;
  word_t io_dat;
  logic  tick;
  iid_t  iid;

  bus_decode u_decode (
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .we_i      (we_i),
    .tga_i     (tga_i),
    .adr_i     (adr_i),
    .inta_i    (inta_i),
    .iid_i     (iid),
    .ram_ack_i (ram_ack),
    .ram_dat_i (ram_dat),
    .io_ack_i  (io_ack),
    .io_dat_i  (io_dat),
    .ram_stb_o (ram_stb),
    .io_stb_o  (io_stb),
    .ack_o     (ack_o),
    .dat_o     (dat_o)
  );

  conv_ram #(
    .RAM_AW (RAM_AW)
  ) u_ram (
    .clk   (clk),
    .rst_i (rst_i),
    .stb_i (ram_stb),
    .we_i  (we_i),
    .adr_i (adr_i),
    .sel_i (sel_i),
    .dat_i (dat_i),
    .dat_o (ram_dat),
    .ack_o (ram_ack)
  );

  io_regs u_io (
    .clk   (clk),
    .rst_i (rst_i),
    .stb_i (io_stb),
    .we_i  (we_i),
    .adr_i (adr_i),
    .dat_i (dat_i),
    .sw_i  (sw_i),
    .dat_o (io_dat),
    .ack_o (io_ack),
    .led_o (led_o)
  );

  pit_timer #(
    .TIMER_RES   (TIMER_RES),
    .TIMER_PHASE (TIMER_PHASE)
  ) u_timer (
    .clk    (clk),
    .rst_i  (rst_i),
    .tick_o (tick)
  );

  // Timer owns line 0
  simple_pic u_pic (
    .clk    (clk),
    .rst_i  (rst_i),
    .irq_i  ({irq_i, tick}),
    .inta_i (inta_i),
    .intr_o (intr_o),
    .iid_o  (iid)
  );

endmodule

/* tb/tb_clk.sv */
// Free-running testbench clock, 40 time unit period, instanced by the testbench top
module tb_clk (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #20 clk_o = ~clk_o;

endmodule

/* tb/pc_soc_chk.sv */
// Concurrent checks on the master bus handshake and the PIC, bound into the SoC top level
module pc_soc_chk
  import pc_soc_pkg::*;
(
  input logic clk,
  input logic rst_i,
  input logic stb_i,
  input logic ack_i,
  input logic ram_stb_i,
  input logic ram_ack_i,
  input logic inta_i,
  input logic intr_i,
  input irq_t pending_i
);

  // Ack only ever starts inside a strobed cycle
  ack_needs_stb: assert property (@(posedge clk) disable iff (rst_i)
    $rose(ack_i) |-> stb_i)
    else $error("ack_o rose while stb_i was low");

  // RAM ack outlives the strobe by one cycle, then drops
  ram_ack_release: assert property (@(posedge clk) disable iff (rst_i)
    $fell(ram_stb_i) |-> ram_ack_i ##1 !ram_ack_i)
    else $error("RAM ack did not fall one cycle after the strobe dropped");

  // Interrupt drops only when an acknowledge retires the last pending line
  intr_falls_on_last_ack: assert property (@(posedge clk) disable iff (rst_i)
    $fell(intr_i) |-> $past(inta_i && $onehot(pending_i)))
    else $error("intr_o fell while other requests were still pending");

endmodule

bind pc_soc_top pc_soc_chk u_chk (
  .clk       (clk),
  .rst_i     (rst_i),
  .stb_i     (stb_i),
  .ack_i     (ack_o),
  .ram_stb_i (ram_stb),
  .ram_ack_i (ram_ack),
  .inta_i    (inta_i),
  .intr_i    (intr_o),
  .pending_i (u_pic.pending)
);

/* tb/pc_soc_tb.sv */
// Testbench acting as the CPU: random bus traffic, interrupt acknowledges and a reference model
module pc_soc_tb;
  import pc_soc_pkg::*;

  localparam int RAM_AW      = 6;
  localparam int TIMER_RES   = 12;
  localparam int TIMER_PHASE = 37;
  localparam int RST_CYCLES  = 8;
  localparam int N_OPS       = 600;
  localparam int N_FILL      = 2 ** RAM_AW;
  // Fill takes 3 cycles per word, a random step at most 5
  localparam int LIMIT = 4 * (2 * (RST_CYCLES + 1) + 3 * N_FILL + 5 * N_OPS + 16);

  logic       clk;
  logic       rst;
  logic       cyc;
  logic       stb;
  logic       we;
  logic       tga;
  logic       inta;
  logic       ack;
  logic       intr;
  addr_t      adr;
  sel_t       sel;
  word_t      dat_w;
  word_t      dat_r;
  word_t      sw;
  word_t      led;
  logic [7:1] irq;

  // Reference model state
  word_t                shadow [N_FILL];
  word_t                led_m;
  logic [TIMER_RES-1:0] acc_m;
  logic [TIMER_RES-1:0] acc_next_m;
  logic                 tick_m;
  irq_t                 lines_m;
  irq_t                 prev_m;
  irq_t                 pend_m;
  logic [31:0]          rng;
  int                   cycles;
  int                   errors;

  tb_clk u_clk (
    .clk_o (clk)
  );

  pc_soc_top #(
    .RAM_AW      (RAM_AW),
    .TIMER_RES   (TIMER_RES),
    .TIMER_PHASE (TIMER_PHASE)
  ) dut0 (
    .clk    (clk),
    .rst_i  (rst),
    .cyc_i  (cyc),
    .stb_i  (stb),
    .we_i   (we),
    .tga_i  (tga),
    .adr_i  (adr),
    .sel_i  (sel),
    .dat_i  (dat_w),
    .inta_i (inta),
    .dat_o  (dat_r),
    .ack_o  (ack),
    .intr_o (intr),
    .irq_i  (irq),
    .sw_i   (sw),
    .led_o  (led)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic iid_t lowest_set(irq_t p);
    for (int i = 0; i < 8; i++) begin
      if (p[i]) begin
        return iid_t'(i);
      end
    end
    return '0;
  endfunction

  // 16-bit port number to bus word address
  function automatic addr_t port_addr(logic [15:0] port);
    return {4'h0, port[15:1]};
  endfunction

  task automatic stop_on_error(string what);
    errors++;
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic compare_word(string name, word_t got, word_t exp);
    assert (got === exp) else begin
      stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // Timer and PIC, cycle by cycle, from pre-edge input values
  always @(posedge clk) begin
    if (rst) begin
      acc_m  = '0;
      tick_m = 1'b0;
      prev_m = '0;
      pend_m = '0;
    end else begin
      lines_m = {irq, tick_m};
      if (inta) begin
        pend_m[lowest_set(pend_m)] = 1'b0;
      end
      pend_m = pend_m | (lines_m & ~prev_m);
      prev_m = lines_m;
      // Tick is high in the cycle the top bit first reads one
      acc_next_m = acc_m + TIMER_RES'(TIMER_PHASE);
      tick_m     = ~acc_m[TIMER_RES-1] & acc_next_m[TIMER_RES-1];
      acc_m      = acc_next_m;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      compare_word("intr_o", 16'(intr), 16'(pend_m != '0));
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      stop_on_error($sformatf("Timeout: run still going after %0d cycles", LIMIT));
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    led_m = '0;
    compare_word("led_o", led, 16'h0000);
    compare_word("intr_o", 16'(intr), 16'h0000);
    compare_word("ack_o", 16'(ack), 16'h0000);
  endtask

  task automatic bus_cycle(input logic io, input logic wr, input addr_t a, input sel_t s,
                           input word_t d, input word_t sw_val, input logic [7:1] irq_val);
    int                waits;
    word_t             exp;
    logic [RAM_AW-1:0] idx;
    idx = a[RAM_AW:1];
    // Expected read data from the port map or the shadow
    if (!io) begin
      exp = shadow[idx];
    end else if (a[19:16] != 4'h0) begin
      exp = 16'hFFFF;
    end else if ({a[15:1], 1'b0} == 16'h0102) begin
      exp = sw_val;
    end else if ({a[15:1], 1'b0} == 16'h0064) begin
      exp = 16'h0010;
    end else begin
      exp = 16'hFFFF;
    end
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    tga   <= io;
    adr   <= a;
    sel   <= s;
    dat_w <= d;
    sw    <= sw_val;
    irq   <= irq_val;
    waits = 0;
    @(negedge clk);
    while (ack !== 1'b1) begin
      waits++;
      @(negedge clk);
    end
    assert (waits == (io ? 0 : 1)) else begin
      stop_on_error($sformatf("ack_o came after %0d wait cycles instead of %0d",
                              waits, io ? 0 : 1));
    end
    if (!wr) begin
      compare_word("dat_o", dat_r, exp);
    end else if (!io) begin
      if (s[0]) begin
        shadow[idx][7:0] = d[7:0];
      end
      if (s[1]) begin
        shadow[idx][15:8] = d[15:8];
      end
    end else if (a[19:16] == 4'h0 && a[15:8] == 8'hF1) begin
      led_m = d;
    end
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    @(negedge clk);
    // RAM ack lingers one cycle, port ack follows the strobe
    compare_word("ack_o", 16'(ack), io ? 16'h0000 : 16'h0001);
    compare_word("led_o", led, led_m);
  endtask

  task automatic acknowledge();
    word_t vec;
    @(posedge clk);
    inta <= 1'b1;
    @(negedge clk);
    vec = 16'h0008 + 16'(lowest_set(pend_m));
    compare_word("dat_o", dat_r, vec);
    @(posedge clk);
    inta <= 1'b0;
    @(negedge clk);
  endtask

  task automatic random_step();
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] q;
    logic        io;
    addr_t       a;
    logic [7:1]  irq_val;
    rng = xorshift32(rng);
    r   = rng;
    if (pend_m != '0 && r[1:0] == 2'b00) begin
      acknowledge();
    end
    rng = xorshift32(rng);
    d   = rng;
    rng = xorshift32(rng);
    q   = rng;
    io  = (r[4:2] >= 3'd5);
    a   = addr_t'(q[31:13]);
    if (io) begin
      case (r[6:5])
        2'd0:    a = port_addr({8'hF1, r[16:9]});
        2'd1:    a = port_addr(16'h0102);
        2'd2:    a = port_addr(16'h0064);
        default: a = addr_t'(q[31:13]);
      endcase
    end
    irq_val = (q[2:0] == 3'd0) ? q[10:4] : irq;
    bus_cycle(io, r[7], a, r[9:8], d[15:0], d[31:16], irq_val);
  endtask

  initial begin
    rst    = 1'b1;
    cyc    = 1'b0;
    stb    = 1'b0;
    we     = 1'b0;
    tga    = 1'b0;
    inta   = 1'b0;
    adr    = '0;
    sel    = '0;
    dat_w  = '0;
    sw     = '0;
    irq    = '0;
    acc_m  = '0;
    tick_m = 1'b0;
    prev_m = '0;
    pend_m = '0;
    led_m  = '0;
    cycles = 0;
    errors = 0;
    rng    = 32'd61;
    apply_reset();
    // Known contents everywhere before random reads
    for (int i = 0; i < N_FILL; i++) begin
      rng = xorshift32(rng);
      bus_cycle(1'b0, 1'b1, addr_t'(i), 2'b11, rng[15:0], sw, irq);
    end
    for (int n = 0; n < N_OPS; n++) begin
      if (n == N_OPS / 2) begin
        apply_reset();
      end
      random_step();
    end
    while (pend_m != '0) begin
      acknowledge();
    end
    compare_word("intr_o", 16'(intr), 16'h0000);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* pc_soc.f */
design/pc_soc_pkg.sv
design/bus_decode.sv
design/conv_ram.sv
design/io_regs.sv
design/pit_timer.sv
design/simple_pic.sv
design/pc_soc_top.sv
tb/tb_clk.sv
tb/pc_soc_chk.sv
tb/pc_soc_tb.sv

/* Bender.yml */
package:
  name: pc_soc

sources:
  - design/pc_soc_pkg.sv
  - design/bus_decode.sv
  - design/conv_ram.sv
  - design/io_regs.sv
  - design/pit_timer.sv
  - design/simple_pic.sv
  - design/pc_soc_top.sv
  - target: test
    files:
      - tb/tb_clk.sv
      - tb/pc_soc_chk.sv
      - tb/pc_soc_tb.sv
